// File: Bender.yml
package:
  name: color_mapper

sources:
  - src/spritePkg.sv
  - src/spriteStageIf.sv
  - src/spriteHitTest.sv
  - src/spriteFetch.sv
  - src/paletteCompositor.sv
  - src/colorMapper.sv
  - target: test
    files:
      - dv/colorMapperChecker.sv
      - dv/colorMapperTb.sv

// File: all.f
src/spritePkg.sv
src/spriteStageIf.sv
src/spriteHitTest.sv
src/spriteFetch.sv
src/paletteCompositor.sv
src/colorMapper.sv
dv/colorMapperChecker.sv
dv/colorMapperTb.sv

// File: dv/colorMapperChecker.sv
//--------------------------------------------------
// assertions on the colour mapper RGB output
// black during reset, no unknown bits after reset,
// channels limited to palette values
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module colorMapperChecker
	import spritePkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire channelT red,
	input wire channelT green,
	input wire channelT blue
);

	int failCount = 0;
	rgbT rgb;

	assign rgb = {red, green, blue};

	// lane 2 is red, 0 is blue
	function automatic bit inPalette(input channelT v, input int lane);
		rgbT colors [7];
		bit hit;
		colors = '{RgbBlack, RgbCyan, RgbBlue, RgbTan, RgbWhite,
			RgbYellowAccent, RgbCyanAccent};
		hit = 1'b0;
		foreach (colors[i])
		begin
			if (colors[i][lane * 8 +: 8] == v)
				hit = 1'b1;
		end
		return hit;
	endfunction

	resetBlack: assert property (@(posedge clk) rst [*PipeDepth] |=> rgb == RgbBlack)
		else
		begin
			failCount = failCount + 1;
			$error("RGB not black after %0d reset cycles", PipeDepth);
		end

	noUnknown: assert property (@(posedge clk) !rst [*PipeDepth] |-> !$isunknown(rgb))
		else
		begin
			failCount = failCount + 1;
			$error("RGB has unknown bits after reset");
		end

	paletteOnly: assert property (@(posedge clk) disable iff (rst)
		inPalette(red, 2) && inPalette(green, 1) && inPalette(blue, 0))
		else
		begin
			failCount = failCount + 1;
			$error("RGB %06h has a channel outside the palettes", rgb);
		end

endmodule

bind colorMapper colorMapperChecker rgbAssert (
	.clk(clk),
	.rst(rst),
	.red(red),
	.green(green),
	.blue(blue)
);

`default_nettype wire

// File: dv/colorMapperTb.sv
//--------------------------------------------------
// testbench for the sprite colour mapper
// clock and reset, hand-built stimulus table, LCG
// random sweep, reference model read from the image
// files, pipelined checks of the RGB output
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module colorMapperTb
	import spritePkg::*;
();

	localparam int ResetCycles = 8;
	localparam int NumRandom = 200;

	typedef struct packed {
		coordT dx;
		coordT dy;
		coordT px;
		coordT py;
		coordT [NumProj-1:0] qx;
		coordT [NumProj-1:0] qy;
	} stimT;

	typedef struct packed {
		stimT s;
		rgbT rgb;
	} rowT;

	logic clk;
	logic rst;
	coordT drawX;
	coordT drawY;
	coordT playerX;
	coordT playerY;
	coordT projX [NumProj];
	coordT projY [NumProj];
	channelT red;
	channelT green;
	channelT blue;

	rowT stimTable [$];
	rgbT expQ [$];
	int tagQ [$];
	colorIdxT refPlayer [PlayerW * PlayerH];
	colorIdxT refProj [ProjW * ProjH];
	logic [31:0] lcgState = 32'he5ee7beb;
	int cycleCount = 0;
	int cycleLimit = 0;

	colorMapper dut_i (
		.clk(clk),
		.rst(rst),
		.drawX(drawX),
		.drawY(drawY),
		.playerX(playerX),
		.playerY(playerY),
		.projX(projX),
		.projY(projY),
		.red(red),
		.green(green),
		.blue(blue)
	);

	always #50 clk = ~clk;

	// run limit
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleLimit > 0 && cycleCount >= cycleLimit)
		begin
			$display("Timeout: the run did not finish within %0d cycles", cycleLimit);
			$display("Test failed");
			$fatal(1, "simulation timeout");
		end
	end

	function automatic logic [31:0] lcgNext();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic int randBelow(input int n);
		logic [31:0] r;
		r = lcgNext();
		return int'(r[31:8]) % n;
	endfunction

	function automatic bit inBox(input int x, input int y, input int bx, input int by,
		input int w, input int h);
		return (x >= bx) && (x < bx + w) && (y >= by) && (y < by + h);
	endfunction

	//--------------------------------------------------
	// reference model
	//--------------------------------------------------
	function automatic rgbT refColor(input stimT s);
		int idx;
		rgbT accent;
		rgbT result;
		bit found;
		found = 1'b0;
		result = 24'h000000;
		if (inBox(int'(s.dx), int'(s.dy), int'(s.px), int'(s.py), PlayerW, PlayerH))
		begin
			idx = refPlayer[(int'(s.dy) - int'(s.py)) * PlayerW + int'(s.dx) - int'(s.px)];
			found = 1'b1;
			case (idx)
				1: result = 24'h000000;
				2: result = 24'h00FFFF;
				3: result = 24'h7B68EE;
				4: result = 24'hFFE7BA;
				5: result = 24'hFFFFFF;
				default: found = 1'b0;
			endcase
		end
		// projectiles in priority order, first opaque one wins
		for (int i = 0; i < NumProj; i++)
		begin
			if (!found && inBox(int'(s.dx), int'(s.dy), int'(s.qx[i]), int'(s.qy[i]),
				ProjW, ProjH))
			begin
				idx = refProj[(int'(s.dy) - int'(s.qy[i])) * ProjW + int'(s.dx) - int'(s.qx[i])];
				accent = (i == 1) ? 24'h00FFFF : 24'hFFFF00;
				found = 1'b1;
				case (idx)
					1: result = 24'h000000;
					5: result = 24'hFFFFFF;
					9: result = accent;
					default: found = 1'b0;
				endcase
			end
		end
		return result;
	endfunction

	task automatic checkValue(input rgbT actual, input rgbT expected, input string what);
		if (actual !== expected)
		begin
			$display("Mismatch at %0d ns: %s, expected %06h, got %06h",
				$time, what, expected, actual);
			$display("Test failed");
			$fatal(1, "RGB check failed");
		end
	endtask

	task automatic addRow(input int dx, input int dy, input int px, input int py,
		input int q0x, input int q0y, input int q1x, input int q1y,
		input int q2x, input int q2y, input rgbT rgb);
		rowT r;
		r.s.dx = coordT'(dx);
		r.s.dy = coordT'(dy);
		r.s.px = coordT'(px);
		r.s.py = coordT'(py);
		r.s.qx[0] = coordT'(q0x);
		r.s.qy[0] = coordT'(q0y);
		r.s.qx[1] = coordT'(q1x);
		r.s.qy[1] = coordT'(q1y);
		r.s.qx[2] = coordT'(q2x);
		r.s.qy[2] = coordT'(q2y);
		r.rgb = rgb;
		stimTable.push_back(r);
	endtask

	// drawX, drawY, player, projectiles 0..2, expected colour
	task automatic buildTable();
		// player palette, player at 100,100
		addRow(103, 102, 100, 100, 200, 100, 300, 100, 400, 100, 24'hFFFFFF);
		addRow(102, 101, 100, 100, 200, 100, 300, 100, 400, 100, 24'hFFE7BA);
		addRow(101, 104, 100, 100, 200, 100, 300, 100, 400, 100, 24'h00FFFF);
		addRow(102, 105, 100, 100, 200, 100, 300, 100, 400, 100, 24'h7B68EE);
		addRow(100, 100, 100, 100, 200, 100, 300, 100, 400, 100, 24'h000000);
		// projectile colours and accents
		addRow(201, 102, 100, 100, 200, 100, 300, 100, 400, 100, 24'hFFFFFF);
		addRow(203, 102, 100, 100, 200, 100, 300, 100, 400, 100, 24'hFFFF00);
		addRow(303, 102, 100, 100, 200, 100, 300, 100, 400, 100, 24'h00FFFF);
		addRow(403, 102, 100, 100, 200, 100, 300, 100, 400, 100, 24'hFFFF00);
		addRow(303, 103, 100, 100, 200, 100, 300, 100, 400, 100, 24'h000000);
		// player on top of projectile 0
		addRow(202, 101, 200, 100, 200, 100, 300, 100, 400, 100, 24'hFFE7BA);
		addRow(203, 100, 200, 100, 200, 100, 300, 100, 400, 100, 24'h000000);
		addRow(200, 103, 200, 100, 200, 100, 300, 100, 400, 100, 24'hFFFFFF);
		addRow(201, 103, 200, 100, 200, 100, 300, 100, 400, 100, 24'hFFFF00);
		// projectile against projectile
		addRow(303, 202, 100, 100, 300, 200, 300, 200, 300, 200, 24'hFFFF00);
		addRow(303, 202, 100, 100, 200, 100, 300, 200, 300, 200, 24'h00FFFF);
		addRow(300, 201, 100, 100, 300, 200, 298, 200, 400, 100, 24'hFFFFFF);
		// box edges of projectile 0, inside then one past
		addRow(200, 103, 100, 100, 200, 100, 300, 100, 400, 100, 24'hFFFFFF);
		addRow(199, 103, 100, 100, 200, 100, 300, 100, 400, 100, 24'h000000);
		addRow(206, 103, 100, 100, 200, 100, 300, 100, 400, 100, 24'hFFFFFF);
		addRow(207, 102, 100, 100, 200, 100, 300, 100, 400, 100, 24'h000000);
		addRow(203, 99, 100, 100, 200, 100, 300, 100, 400, 100, 24'h000000);
		addRow(203, 106, 100, 100, 200, 100, 300, 100, 400, 100, 24'hFFFFFF);
		addRow(203, 107, 100, 100, 200, 100, 300, 100, 400, 100, 24'h000000);
		// player right edge
		addRow(106, 105, 100, 100, 200, 100, 300, 100, 400, 100, 24'h00FFFF);
		addRow(108, 105, 100, 100, 200, 100, 300, 100, 400, 100, 24'h000000);
	endtask

	task automatic driveStim(input stimT s);
		drawX = s.dx;
		drawY = s.dy;
		playerX = s.px;
		playerY = s.py;
		for (int i = 0; i < NumProj; i++)
		begin
			projX[i] = s.qx[i];
			projY[i] = s.qy[i];
		end
	endtask

	// compare the pixel that entered PipeDepth cycles ago
	task automatic popCheck(input bit drain);
		rgbT expected;
		int tag;
		string what;
		if (expQ.size() == PipeDepth || (drain && expQ.size() > 0))
		begin
			expected = expQ.pop_front();
			tag = tagQ.pop_front();
			if (tag < stimTable.size())
				what = $sformatf("table row %0d", tag);
			else
				what = $sformatf("random pixel %0d", tag - stimTable.size());
			checkValue({red, green, blue}, expected, what);
		end
	endtask

	task automatic applyPixel(input stimT s, input rgbT expected, input int tag);
		@(posedge clk);
		#10;
		popCheck(1'b0);
		driveStim(s);
		expQ.push_back(expected);
		tagQ.push_back(tag);
	endtask

	//--------------------------------------------------
	// main sequence
	//--------------------------------------------------
	initial
	begin
		stimT s;
		int baseX;
		int baseY;
		clk = 1'b0;
		rst = 1'b1;
		s = '0;
		driveStim(s);
		$readmemh(PlayerMemFile, refPlayer);
		$readmemh(ProjMemFile, refProj);
		buildTable();
		cycleLimit = 2 * (ResetCycles + stimTable.size() + NumRandom + PipeDepth);

		repeat (ResetCycles)
		begin
			@(posedge clk);
			#10;
			checkValue({red, green, blue}, 24'h000000, "output during reset");
		end
		rst = 1'b0;

		// one pixel per cycle, back to back
		foreach (stimTable[n])
		begin
			applyPixel(stimTable[n].s, stimTable[n].rgb, n);
		end

		// sprites clustered around a base point so that they overlap
		for (int n = 0; n < NumRandom; n++)
		begin
			baseX = 20 + randBelow(560);
			baseY = 20 + randBelow(400);
			s.px = coordT'(baseX + randBelow(12));
			s.py = coordT'(baseY + randBelow(12));
			for (int i = 0; i < NumProj; i++)
			begin
				s.qx[i] = coordT'(baseX + randBelow(12));
				s.qy[i] = coordT'(baseY + randBelow(12));
			end
			s.dx = coordT'(baseX - 2 + randBelow(24));
			s.dy = coordT'(baseY - 2 + randBelow(24));
			applyPixel(s, refColor(s), stimTable.size() + n);
		end

		repeat (PipeDepth)
		begin
			@(posedge clk);
			#10;
			popCheck(1'b1);
		end

		if (dut_i.rgbAssert.failCount == 0)
		begin
			$display("Test passed");
			$finish;
		end
		else
		begin
			$display("Checker reported %0d assertion failures", dut_i.rgbAssert.failCount);
			$display("Test failed");
			$fatal(1, "assertion failures in the checker");
		end
	end

endmodule

`default_nettype wire

// File: src/colorMapper.sv
//--------------------------------------------------
// sprite colour mapper top level
// three-stage pipeline: hit test, image fetch,
// palette and priority; colour out 3 cycles after
// the draw coordinate
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module colorMapper
	import spritePkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire coordT drawX,
	input wire coordT drawY,
	input wire coordT playerX,
	input wire coordT playerY,
	input wire coordT projX [NumProj],
	input wire coordT projY [NumProj],
	output channelT red,
	output channelT green,
	output channelT blue
);

	spriteStageIf stageBus ();

	colorIdxT playerIdx;
	colorIdxT projIdx [NumProj];

	// stage 1
	spriteHitTest hitTest (
		.clk(clk),
		.rst(rst),
		.drawX(drawX),
		.drawY(drawY),
		.playerX(playerX),
		.playerY(playerY),
		.projX(projX),
		.projY(projY),
		.stageOut(stageBus.producer)
	);

	// stage 2
	spriteFetch fetch (
		.clk(clk),
		.rst(rst),
		.stageIn(stageBus.consumer),
		.playerIdx(playerIdx),
		.projIdx(projIdx)
	);

	// stage 3
	paletteCompositor compositor (
		.clk(clk),
		.rst(rst),
		.playerIdx(playerIdx),
		.projIdx(projIdx),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

`default_nettype wire

// File: src/paletteCompositor.sv
//--------------------------------------------------
// stage 3 of the colour pipeline
// per-sprite palette lookup, priority resolve
// (player, projectile 0, 1, 2, black background)
// and the registered RGB output
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module paletteCompositor
	import spritePkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire colorIdxT playerIdx,
	input wire colorIdxT projIdx [NumProj],
	output channelT red,
	output channelT green,
	output channelT blue
);

	typedef struct packed {
		logic opaque;
		rgbT rgb;
	} pixelT;

	function automatic pixelT playerLookup(input colorIdxT idx);
		pixelT px;
		px.opaque = 1'b1;
		case (playerColorE'(idx))
			PlayerBlack: px.rgb = RgbBlack;
			PlayerCyan: px.rgb = RgbCyan;
			PlayerBlue: px.rgb = RgbBlue;
			PlayerTan: px.rgb = RgbTan;
			PlayerWhite: px.rgb = RgbWhite;
			default:
			begin
				px.opaque = 1'b0;
				px.rgb = RgbBlack;
			end
		endcase
		return px;
	endfunction

	function automatic pixelT projLookup(input colorIdxT idx, input rgbT accent);
		pixelT px;
		px.opaque = 1'b1;
		case (projColorE'(idx))
			ProjBlack: px.rgb = RgbBlack;
			ProjWhite: px.rgb = RgbWhite;
			ProjAccent: px.rgb = accent;
			default:
			begin
				px.opaque = 1'b0;
				px.rgb = RgbBlack;
			end
		endcase
		return px;
	endfunction

	pixelT playerPx;
	pixelT projPx [NumProj];
	rgbT mixRgb;

	//--------------------------------------------------
	// priority resolve
	//--------------------------------------------------
	always_comb
	begin
		playerPx = playerLookup(playerIdx);
		for (int i = 0; i < NumProj; i++)
		begin
			projPx[i] = projLookup(projIdx[i],
				ProjCyanSel[i] ? RgbCyanAccent : RgbYellowAccent);
		end
		// background first, then overwrite from lowest to highest priority
		mixRgb = RgbBlack;
		for (int i = NumProj - 1; i >= 0; i--)
		begin
			if (projPx[i].opaque)
			begin
				mixRgb = projPx[i].rgb;
			end
		end
		if (playerPx.opaque)
		begin
			mixRgb = playerPx.rgb;
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			red <= '0;
			green <= '0;
			blue <= '0;
		end
		else
		begin
			red <= mixRgb[23:16];
			green <= mixRgb[15:8];
			blue <= mixRgb[7:0];
		end
	end

endmodule

`default_nettype wire

// File: src/player.mem
// player image, 8 rows top to bottom, 8 hex colour indices per row
// left column first, 0 is transparent
0 0 1 1 1 1 0 0
0 1 4 4 4 4 1 0
0 1 4 5 4 5 1 0
0 0 4 4 4 4 0 0
1 2 2 2 2 2 2 1
0 2 3 2 2 3 2 0
0 0 3 3 3 3 0 0
0 1 1 0 0 1 1 0

// File: src/projectile.mem
// projectile image, 7 rows top to bottom, 7 hex colour indices per row
// left column first, 0 is transparent
0 0 0 5 0 0 0
0 0 5 9 5 0 0
0 5 9 9 9 5 0
5 9 9 1 9 9 5
0 5 9 9 9 5 0
0 0 5 9 5 0 0
0 0 0 5 0 0 0

// File: src/spriteFetch.sv
//--------------------------------------------------
// stage 2 of the colour pipeline
// player and projectile image ROMs, one registered
// read per sprite, index 0 where a sprite misses
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module spriteFetch
	import spritePkg::*;
(
	input wire logic clk,
	input wire logic rst,
	spriteStageIf.consumer stageIn,
	output colorIdxT playerIdx,
	output colorIdxT projIdx [NumProj]
);

	// images stored row by row
	colorIdxT playerRom [PlayerRomDepth];
	colorIdxT projRom [ProjRomDepth];

	playerAddrT playerAddr;
	projAddrT projAddr [NumProj];

	initial
	begin
		$readmemh(PlayerMemFile, playerRom);
		$readmemh(ProjMemFile, projRom);
	end

	always_comb
	begin
		playerAddr = playerAddrT'(stageIn.playerRow * PlayerW + stageIn.playerCol);
		// all projectiles share one image, one read port each
		for (int i = 0; i < NumProj; i++)
		begin
			projAddr[i] = projAddrT'(stageIn.projRow[i] * ProjW + stageIn.projCol[i]);
		end
	end

	//--------------------------------------------------
	// registered reads
	//--------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			playerIdx <= '0;
			for (int i = 0; i < NumProj; i++)
			begin
				projIdx[i] <= '0;
			end
		end
		else
		begin
			playerIdx <= stageIn.playerHit ? playerRom[playerAddr] : '0;
			for (int i = 0; i < NumProj; i++)
			begin
				projIdx[i] <= stageIn.projHit[i] ? projRom[projAddr[i]] : '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/spriteHitTest.sv
//--------------------------------------------------
// stage 1 of the colour pipeline
// bounding-box test of the draw coordinate against
// the player and every projectile, registered hits
// and in-box offsets
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module spriteHitTest
	import spritePkg::*;
(
	input wire logic clk,
	input wire logic rst,
	input wire coordT drawX,
	input wire coordT drawY,
	input wire coordT playerX,
	input wire coordT playerY,
	input wire coordT projX [NumProj],
	input wire coordT projY [NumProj],
	spriteStageIf.producer stageOut
);

	coordT playerDx;
	coordT playerDy;
	logic playerIn;
	coordT projDx [NumProj];
	coordT projDy [NumProj];
	logic projIn [NumProj];

	// a coordinate left of or above the box wraps to a large offset,
	// so a single compare per axis gives the half-open bounds
	always_comb
	begin
		playerDx = drawX - playerX;
		playerDy = drawY - playerY;
		playerIn = (playerDx < PlayerW) && (playerDy < PlayerH);
		for (int i = 0; i < NumProj; i++)
		begin
			projDx[i] = drawX - projX[i];
			projDy[i] = drawY - projY[i];
			projIn[i] = (projDx[i] < ProjW) && (projDy[i] < ProjH);
		end
	end

	//--------------------------------------------------
	// stage register
	//--------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			stageOut.playerHit <= 1'b0;
			stageOut.playerRow <= '0;
			stageOut.playerCol <= '0;
			for (int i = 0; i < NumProj; i++)
			begin
				stageOut.projHit[i] <= 1'b0;
				stageOut.projRow[i] <= '0;
				stageOut.projCol[i] <= '0;
			end
		end
		else
		begin
			stageOut.playerHit <= playerIn;
			// offsets held at zero outside the box
			stageOut.playerRow <= playerIn ? playerOffT'(playerDy) : '0;
			stageOut.playerCol <= playerIn ? playerOffT'(playerDx) : '0;
			for (int i = 0; i < NumProj; i++)
			begin
				stageOut.projHit[i] <= projIn[i];
				stageOut.projRow[i] <= projIn[i] ? projOffT'(projDy[i]) : '0;
				stageOut.projCol[i] <= projIn[i] ? projOffT'(projDx[i]) : '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: src/spritePkg.sv
//--------------------------------------------------
// shared definitions for the sprite colour mapper
// screen and sprite geometry, coordinate and index
// types, palette index enums, RGB colour constants
// and the image data file names
//--------------------------------------------------
`default_nettype none

package spritePkg;

	// screen and sprite geometry
	localparam int ScreenW = 640;
	localparam int ScreenH = 480;
	localparam int PlayerW = 8;
	localparam int PlayerH = 8;
	localparam int ProjW = 7;
	localparam int ProjH = 7;
	localparam int NumProj = 3;

	// hit test, fetch, palette
	localparam int PipeDepth = 3;

	localparam int PlayerRomDepth = PlayerW * PlayerH;
	localparam int ProjRomDepth = ProjW * ProjH;

	// projectiles drawn with the cyan accent, the rest get yellow
	localparam logic [NumProj-1:0] ProjCyanSel = 3'b010;

	localparam PlayerMemFile = "src/player.mem";
	localparam ProjMemFile = "src/projectile.mem";

	typedef logic [$clog2(ScreenW)-1:0] coordT;
	typedef logic [3:0] colorIdxT;
	typedef logic [7:0] channelT;
	typedef logic [23:0] rgbT;

	// offsets inside a sprite box, rows and columns alike
	typedef logic [$clog2(PlayerW > PlayerH ? PlayerW : PlayerH)-1:0] playerOffT;
	typedef logic [$clog2(ProjW > ProjH ? ProjW : ProjH)-1:0] projOffT;
	typedef logic [$clog2(PlayerRomDepth)-1:0] playerAddrT;
	typedef logic [$clog2(ProjRomDepth)-1:0] projAddrT;

	//--------------------------------------------------
	// palette index codes, anything else is transparent
	//--------------------------------------------------
	typedef enum logic [3:0] {
		PlayerBlack = 4'd1,
		PlayerCyan = 4'd2,
		PlayerBlue = 4'd3,
		PlayerTan = 4'd4,
		PlayerWhite = 4'd5
	} playerColorE;

	typedef enum logic [3:0] {
		ProjBlack = 4'd1,
		ProjWhite = 4'd5,
		ProjAccent = 4'd9
	} projColorE;

	// colours
	localparam rgbT RgbBlack = 24'h000000;
	localparam rgbT RgbCyan = 24'h00FFFF;
	localparam rgbT RgbBlue = 24'h7B68EE;
	localparam rgbT RgbTan = 24'hFFE7BA;
	localparam rgbT RgbWhite = 24'hFFFFFF;
	localparam rgbT RgbYellowAccent = 24'hFFFF00;
	localparam rgbT RgbCyanAccent = 24'h00FFFF;

endpackage

`default_nettype wire

// File: src/spriteStageIf.sv
//--------------------------------------------------
// hit-test to fetch stage bus
// hit flags and in-box offsets for the player and
// each projectile
//--------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface spriteStageIf
	import spritePkg::*;
();

	logic playerHit;
	playerOffT playerRow;
	playerOffT playerCol;

	logic projHit [NumProj];
	projOffT projRow [NumProj];
	projOffT projCol [NumProj];

	modport producer (output playerHit, playerRow, playerCol, projHit, projRow, projCol);
	modport consumer (input playerHit, playerRow, playerCol, projHit, projRow, projCol);

endinterface

`default_nettype wire
